// ==== project.f ====
+incdir+.
fifo_bus_pkg.sv
fifo_sram_pkg.sv
word_buffer.sv
sram_ring_ctrl.sv
byte_readout.sv
fifo_regs.sv
sram_fifo_top.sv
tb_sram_model.sv
tb_sram_fifo.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the SRAM FIFO testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/100ps \
    -f project.f --top-module tb_sram_fifo
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/Vtb_sram_fifo)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "Simulation passed"; then
    exit 0
fi
exit 1

// ==== tb_sram_fifo.sv ====
// module tb_sram_fifo, clock, source and reader stimulus, byte reference, checks and timeout
`default_nettype none
`include "fifo_config.svh"

module tb_sram_fifo;
    timeunit 1ns;
    timeprecision 100ps;

    import fifo_bus_pkg::*;
    import fifo_sram_pkg::*;

    localparam int unsigned FULL_WORDS = `SRAM_DEPTH / 2 + `WORD_BUF_DEPTH + 8; // more than fits
    localparam int unsigned NF_SET = (127 + 1) * `SRAM_DEPTH / 256; // halfwords
    localparam int unsigned NF_CLR = (63 + 1) * `SRAM_DEPTH / 256;
    // every byte of every test at up to 8 cycles, plus register traffic
    localparam int unsigned TIMEOUT_CYCLES =
        (40 + 10 + FULL_WORDS + NF_SET / 2 + NF_SET) * 4 * 8 + 5000;

    logic        BUS_CLK;
    logic        RST;
    bus_req_t    bus;
    logic        fifo_empty_in;
    logic [31:0] fifo_data;
    logic [15:0] sram_rdata;
    logic        usb_read;
    logic [7:0]  bus_data_out;
    logic        read_next;
    sram_cmd_t   sram;
    logic        byte_ready;
    logic [7:0]  usb_data;
    logic        fifo_not_empty;
    logic        fifo_full;
    logic        fifo_near_full;
    logic        fifo_read_error;

    logic [31:0] src_q[$];      // words still at the source
    logic [31:0] sent_words[$]; // words taken by the DUT, in order
    int unsigned rd_index;      // bytes read since the last reset
    int unsigned failures;
    int unsigned cycle_count;

    sram_fifo_top i_sram_fifo_top (.*);
    tb_sram_model i_sram_model (.*);

    initial begin
        BUS_CLK = 1'b0;
        forever #4 BUS_CLK = ~BUS_CLK;
    end

    // byte n of the stream, low byte of each word first
    function automatic logic [7:0] expected_byte(input int unsigned n);
        logic [31:0] word;
        word = sent_words[n / 4];
        return word[8 * (n % 4) +: 8];
    endfunction

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            failures++;
            $display("CHECK FAILED at %0t ns: %s is 0x%0h, expected 0x%0h",
                     $time, name, actual, expected);
            $display("Simulation failed");
            $fatal(1, "stopping at the first mismatch");
        end
    endtask

    task automatic next_drive_point;
        @(posedge BUS_CLK);
        #1;
    endtask

    task automatic reg_write(input logic [15:0] addr, input logic [7:0] data);
        next_drive_point();
        bus.add = addr;
        bus.data_in = data;
        bus.wr = 1'b1;
        next_drive_point();
        bus.wr = 1'b0;
    endtask

    // read data is registered, so it shows up one edge after the address
    task automatic reg_read(input logic [15:0] addr, output logic [7:0] value);
        next_drive_point();
        bus.add = addr;
        bus.rd = 1'b1;
        next_drive_point();
        bus.rd = 1'b0;
        @(negedge BUS_CLK);
        value = bus_data_out;
    endtask

    task automatic read_size(output logic [23:0] size);
        logic [7:0] b;
        reg_read(REG_SIZE0, b);
        size[7:0] = b;
        reg_read(REG_SIZE1, b);
        size[15:8] = b;
        reg_read(REG_SIZE2, b);
        size[23:16] = b;
    endtask

    task automatic send_words(input int unsigned n);
        repeat (n) src_q.push_back($urandom());
    endtask

    task automatic pulse_usb_read;
        next_drive_point();
        usb_read = 1'b1;
        next_drive_point();
        usb_read = 1'b0;
    endtask

    task automatic read_bytes(input int unsigned n, input bit gaps);
        for (int unsigned i = 0; i < n; i++) begin
            do @(negedge BUS_CLK); while (!byte_ready);
            pulse_usb_read();
            if (gaps) begin
                repeat ($urandom_range(3, 0)) @(posedge BUS_CLK);
            end
        end
    endtask

    // source drained, buffer empty, no SRAM access and readout settled
    task automatic wait_idle;
        do @(negedge BUS_CLK);
        while (src_q.size() != 0 || !fifo_empty_in || !sram.we_b || !sram.oe_b
               || (!byte_ready && fifo_not_empty));
    endtask

    task automatic check_level(input int unsigned hw, input logic near_full);
        logic [23:0] size;
        wait_idle();
        read_size(size);
        check_value("byte count", 32'(size), 32'(2 * hw));
        check_value("fifo_near_full", 32'(fifo_near_full), 32'(near_full));
        // one halfword sits outside the ring once the readout holds it
        check_value("fifo_not_empty", 32'(fifo_not_empty), 32'(hw > 1));
    endtask

    initial begin : timeout_watch
        cycle_count = 0;
        forever begin
            @(posedge BUS_CLK);
            cycle_count++;
            if (cycle_count >= TIMEOUT_CYCLES) begin
                $display("timeout, no end of the test sequence after %0d cycles", cycle_count);
                $display("Simulation failed");
                $fatal(1, "run stopped by the timeout");
            end
        end
    end

    // take decision sampled mid-cycle, new word driven after the edge
    initial begin : source_feed
        logic accept;
        forever begin
            @(negedge BUS_CLK);
            accept = !fifo_empty_in && read_next;
            next_drive_point();
            if (accept) begin
                sent_words.push_back(src_q.pop_front());
            end
            fifo_empty_in = (src_q.size() == 0);
            fifo_data = (src_q.size() != 0) ? src_q[0] : 32'h0;
        end
    end

    initial begin : compare_reads
        forever begin
            @(negedge BUS_CLK);
            if (usb_read && byte_ready) begin
                check_value("usb_data", 32'(usb_data), 32'(expected_byte(rd_index)));
                rd_index++;
            end
        end
    end

    initial begin : main_sequence
        logic [7:0]  value;
        int unsigned words_before;
        void'($urandom(53582));
        RST = 1'b1;
        bus = '0;
        fifo_empty_in = 1'b1;
        fifo_data = 32'h0;
        usb_read = 1'b0;
        rd_index = 0;
        failures = 0;
        repeat (10) @(posedge BUS_CLK);
        #1 RST = 1'b0;

        // version and reset state
        @(negedge BUS_CLK);
        check_value("read_next", 32'(read_next), 32'd1);
        check_value("byte_ready", 32'(byte_ready), 32'd0);
        check_value("fifo_near_full", 32'(fifo_near_full), 32'd0);
        check_value("fifo_read_error", 32'(fifo_read_error), 32'd0);
        check_value("fifo_not_empty", 32'(fifo_not_empty), 32'd0);
        check_value("sram.we_b", 32'(sram.we_b), 32'd1);
        check_value("sram.oe_b", 32'(sram.oe_b), 32'd1);
        reg_read(REG_CTRL, value);
        check_value("version", 32'(value), 32'(`FIFO_VERSION));
        reg_read(REG_RDERR, value);
        check_value("read errors", 32'(value), 32'd0);

        send_words(40); // streaming with random reader gaps
        read_bytes(160, 1'b1);
        check_level(0, 1'b0);

        send_words(10);
        check_level(20, 1'b0);
        read_bytes(3, 1'b0);
        check_level(19, 1'b0); // second halfword still held
        read_bytes(37, 1'b0);

        // overflow the ring and the buffer, then drain
        words_before = sent_words.size();
        send_words(FULL_WORDS);
        do @(negedge BUS_CLK); while (!fifo_full);
        do @(negedge BUS_CLK); while (read_next);
        check_value("fifo_full", 32'(fifo_full), 32'd1);
        // ring and held halfword take one SRAM depth and the buffer fills up
        check_value("words taken", 32'(sent_words.size() - words_before),
                    32'(`SRAM_DEPTH / 2 + `WORD_BUF_DEPTH));
        read_bytes(4 * FULL_WORDS, 1'b0);
        check_level(0, 1'b0);

        // near-full hysteresis
        reg_write(REG_SIZE0, 8'd127);
        reg_write(REG_SIZE1, 8'd63);
        send_words(NF_SET / 2 - 1);
        check_level(NF_SET - 2, 1'b0);
        send_words(1);
        check_level(NF_SET, 1'b1);
        read_bytes(2 * (NF_SET - NF_CLR - 1), 1'b0);
        check_level(NF_CLR + 1, 1'b1);
        read_bytes(2, 1'b0);
        check_level(NF_CLR, 1'b0);
        read_bytes(2 * NF_CLR, 1'b0);
        check_level(0, 1'b0);

        // read errors, then soft reset with data stored
        repeat (3) pulse_usb_read();
        reg_read(REG_RDERR, value);
        check_value("read errors", 32'(value), 32'd3);
        check_value("fifo_read_error", 32'(fifo_read_error), 32'd1);
        send_words(NF_SET / 2);
        check_level(NF_SET, 1'b1);
        reg_write(REG_CTRL, 8'd0);
        sent_words.delete();
        rd_index = 0;
        reg_read(REG_RDERR, value);
        check_value("read errors", 32'(value), 32'd0);
        check_value("fifo_read_error", 32'(fifo_read_error), 32'd0);
        check_value("read_next", 32'(read_next), 32'd1);
        check_value("byte_ready", 32'(byte_ready), 32'd0);
        check_value("fifo_near_full", 32'(fifo_near_full), 32'd0);
        check_level(0, 1'b0);
        reg_read(REG_CTRL, value);
        check_value("version", 32'(value), 32'(`FIFO_VERSION));

        // default thresholds keep this level below near-full
        send_words(NF_SET / 2);
        check_level(NF_SET, 1'b0);
        read_bytes(4, 1'b0); // first word after the soft reset

        if (failures == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb_sram_model.sv ====
// module tb_sram_model, behavioural SRAM with asynchronous read and strobed write
`default_nettype none
`include "fifo_config.svh"

module tb_sram_model (
    input  wire                              BUS_CLK,
    input  wire fifo_sram_pkg::sram_cmd_t    sram,
    output logic [15:0]                      sram_rdata
);
    timeunit 1ns;
    timeprecision 100ps;

    localparam int unsigned DEPTH = `SRAM_DEPTH;
    localparam int unsigned IDX_W = $clog2(DEPTH);

    logic [15:0]      mem [DEPTH];
    logic [IDX_W-1:0] idx;

    assign idx = sram.addr[IDX_W-1:0]; // the ring never leaves the first DEPTH halfwords

    // power-up contents, different at every address
    initial begin
        for (int a = 0; a < DEPTH; a++) begin
            mem[a] = 16'(a * 40503) ^ 16'hc3a5;
        end
    end

    // write strobe sampled on the clock edge
    always @(posedge BUS_CLK) begin
        if (!sram.we_b) begin
            mem[idx] <= sram.wdata;
        end
    end

    assign sram_rdata = sram.oe_b ? 16'h0000 : mem[idx]; // data valid while oe_b is low

endmodule

`default_nettype wire

// ==== sram_fifo_top.sv ====
// module sram_fifo_top, word buffer, ring controller, byte readout and register bank
`default_nettype none

module sram_fifo_top (
    input  wire                            BUS_CLK,
    input  wire                            RST,
    input  wire fifo_bus_pkg::bus_req_t    bus,
    input  wire                            fifo_empty_in,
    input  wire  [31:0]                    fifo_data,
    input  wire  [15:0]                    sram_rdata,
    input  wire                            usb_read,
    output logic [7:0]                     bus_data_out,
    output logic                           read_next,
    output fifo_sram_pkg::sram_cmd_t       sram,
    output logic                           byte_ready,
    output logic [7:0]                     usb_data,
    output logic                           fifo_not_empty,
    output logic                           fifo_full,
    output logic                           fifo_near_full,
    output logic                           fifo_read_error
);

    import fifo_sram_pkg::*;

    logic         clr;
    logic         buf_empty;
    logic [31:0]  buf_word;
    logic         buf_pop;
    logic         fetch;
    logic [7:0]   rd_err_count;
    fill_status_t fill;

    word_buffer i_word_buffer (
        .BUS_CLK       (BUS_CLK),
        .clr           (clr),
        .fifo_empty_in (fifo_empty_in),
        .fifo_data     (fifo_data),
        .buf_pop       (buf_pop),
        .read_next     (read_next),
        .buf_empty     (buf_empty),
        .buf_word      (buf_word)
    );

    sram_ring_ctrl i_sram_ring_ctrl (
        .BUS_CLK   (BUS_CLK),
        .clr       (clr),
        .buf_empty (buf_empty),
        .buf_word  (buf_word),
        .fetch     (fetch),
        .buf_pop   (buf_pop),
        .sram      (sram),
        .fill      (fill)
    );

    byte_readout i_byte_readout (
        .BUS_CLK      (BUS_CLK),
        .clr          (clr),
        .fill         (fill),
        .sram_rdata   (sram_rdata),
        .usb_read     (usb_read),
        .fetch        (fetch),
        .byte_ready   (byte_ready),
        .usb_data     (usb_data),
        .rd_err_count (rd_err_count)
    );

    fifo_regs i_fifo_regs (
        .BUS_CLK        (BUS_CLK),
        .RST            (RST),
        .bus            (bus),
        .fill           (fill),
        .byte_ready     (byte_ready),
        .rd_err_count   (rd_err_count),
        .clr            (clr),
        .bus_data_out   (bus_data_out),
        .fifo_near_full (fifo_near_full)
    );

    assign fifo_not_empty  = !fill.empty;
    assign fifo_full       = fill.full;
    assign fifo_read_error = (rd_err_count != 8'd0);

endmodule

`default_nettype wire

// ==== fifo_regs.sv ====
// module fifo_regs, register bank with soft reset, byte count and near-full flag
`default_nettype none
`include "fifo_config.svh"

module fifo_regs (
    input  wire                                BUS_CLK,
    input  wire                                RST,
    input  wire fifo_bus_pkg::bus_req_t        bus,
    input  wire fifo_sram_pkg::fill_status_t   fill,
    input  wire                                byte_ready,
    input  wire  [7:0]                         rd_err_count,
    output logic                               clr,
    output logic [7:0]                         bus_data_out,
    output logic                               fifo_near_full
);

    import fifo_bus_pkg::*;

    localparam int unsigned DEPTH      = `SRAM_DEPTH;
    localparam logic [7:0]  AF_DEFAULT = 8'(255 * `ALMOST_FULL_PCT / 100);
    localparam logic [7:0]  AE_DEFAULT = 8'(255 * `ALMOST_EMPTY_PCT / 100);

    logic [7:0]            almost_full;
    logic [7:0]            almost_empty;
    logic [`SRAM_ADDR_W:0] hw_count;   // ring plus the held halfword
    logic [23:0]           byte_count;
    logic [31:0]           hw_level;
    logic [31:0]           set_level;
    logic [31:0]           clr_level;

    assign clr = RST || (bus.wr && bus.add == REG_CTRL);

    // threshold writes share addresses 1 and 2 with the size readback
    always_ff @(posedge BUS_CLK) begin
        if (clr) begin
            almost_full  <= AF_DEFAULT;
            almost_empty <= AE_DEFAULT;
        end else if (bus.wr && bus.add == REG_SIZE0) begin
            almost_full <= bus.data_in;
        end else if (bus.wr && bus.add == REG_SIZE1) begin
            almost_empty <= bus.data_in;
        end
    end

    always_ff @(posedge BUS_CLK) begin
        hw_count <= fill.count + (`SRAM_ADDR_W + 1)'(byte_ready);
    end

    assign byte_count = {2'b00, hw_count, 1'b0};
    assign hw_level   = 32'(hw_count);
    assign set_level  = ((32'(almost_full) + 32'd1) * DEPTH) >> 8;
    assign clr_level  = ((32'(almost_empty) + 32'd1) * DEPTH) >> 8;

    always_ff @(posedge BUS_CLK) begin
        case (bus.add)
            REG_CTRL:  bus_data_out <= 8'(`FIFO_VERSION);
            REG_SIZE0: bus_data_out <= byte_count[7:0];
            REG_SIZE1: bus_data_out <= byte_count[15:8];
            REG_SIZE2: bus_data_out <= byte_count[23:16];
            REG_RDERR: bus_data_out <= rd_err_count;
            default:   bus_data_out <= 8'd0;
        endcase
    end

    // hysteresis, set high and clear low
    always_ff @(posedge BUS_CLK) begin
        if (clr) begin
            fifo_near_full <= 1'b0;
        end else if (hw_level >= set_level) begin
            fifo_near_full <= 1'b1;
        end else if (hw_level <= clr_level || hw_count == '0) begin
            fifo_near_full <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// ==== byte_readout.sv ====
// module byte_readout, halfword prefetch FSM, byte select and read error counter
`default_nettype none

module byte_readout (
    input  wire                                BUS_CLK,
    input  wire                                clr,
    input  wire fifo_sram_pkg::fill_status_t   fill,
    input  wire  [15:0]                        sram_rdata,
    input  wire                                usb_read,
    output logic                               fetch,
    output logic                               byte_ready,
    output logic [7:0]                         usb_data,
    output logic [7:0]                         rd_err_count
);

    import fifo_sram_pkg::*;

    rd_state_e   state;
    rd_state_e   state_next;
    logic        byte_sel;  // 0 low byte, 1 high byte
    logic [15:0] hold_hw;

    always_comb begin
        state_next = state;
        case (state)
            RD_WAIT: begin
                if (!fill.empty) begin
                    state_next = RD_FETCH;
                end
            end
            RD_FETCH: state_next = RD_HOLD;
            RD_HOLD: begin
                if (usb_read && byte_sel) begin // high byte taken
                    state_next = fill.empty ? RD_WAIT : RD_FETCH;
                end
            end
            default: state_next = RD_WAIT;
        endcase
    end

    always_ff @(posedge BUS_CLK) begin
        if (clr) begin
            state    <= RD_WAIT;
            byte_sel <= 1'b0;
        end else begin
            state <= state_next;
            if (state == RD_FETCH) begin
                byte_sel <= 1'b0;
            end else if (state == RD_HOLD && usb_read) begin
                byte_sel <= !byte_sel;
            end
        end
    end

    always_ff @(posedge BUS_CLK) begin
        if (state == RD_FETCH) begin
            hold_hw <= sram_rdata; // async SRAM data settles within the cycle
        end
    end

    assign fetch      = (state == RD_FETCH);
    assign byte_ready = (state == RD_HOLD);
    assign usb_data   = byte_sel ? hold_hw[15:8] : hold_hw[7:0];

    // saturating count of reads with nothing to give
    always_ff @(posedge BUS_CLK) begin
        if (clr) begin
            rd_err_count <= 8'd0;
        end else if (usb_read && !byte_ready && rd_err_count != 8'hff) begin
            rd_err_count <= rd_err_count + 8'd1;
        end
    end

    a_no_fetch_empty: assert property (@(posedge BUS_CLK) disable iff (clr)
        fetch |-> !fill.empty)
        else $error("fetch issued on an empty ring");

endmodule

`default_nettype wire

// ==== sram_ring_ctrl.sv ====
// module sram_ring_ctrl, ring pointers, fill detection and SRAM command generation
`default_nettype none
`include "fifo_config.svh"

module sram_ring_ctrl (
    input  wire                           BUS_CLK,
    input  wire                           clr,
    input  wire                           buf_empty,
    input  wire  [31:0]                   buf_word,
    input  wire                           fetch,
    output logic                          buf_pop,
    output fifo_sram_pkg::sram_cmd_t      sram,
    output fifo_sram_pkg::fill_status_t   fill
);

    localparam int unsigned DEPTH  = `SRAM_DEPTH;
    localparam int unsigned ADDR_W = `SRAM_ADDR_W;

    logic [ADDR_W-1:0] wr_ptr;
    logic [ADDR_W-1:0] rd_ptr;
    logic [ADDR_W-1:0] wr_ptr_next;
    logic [ADDR_W-1:0] rd_ptr_next;
    logic [ADDR_W:0]   hw_count;
    logic              ring_empty;
    logic              ring_full;
    logic              write_hw;
    logic              read_hw;

    // wrap at the ring end, not at the address width
    always_comb begin
        if (wr_ptr == ADDR_W'(DEPTH - 1)) begin
            wr_ptr_next = '0;
        end else begin
            wr_ptr_next = wr_ptr + 1'b1;
        end
        if (rd_ptr == ADDR_W'(DEPTH - 1)) begin
            rd_ptr_next = '0;
        end else begin
            rd_ptr_next = rd_ptr + 1'b1;
        end
    end

    // one slot stays free so full and empty differ
    assign ring_empty = (wr_ptr == rd_ptr);
    assign ring_full  = (wr_ptr_next == rd_ptr);

    always_comb begin
        if (wr_ptr >= rd_ptr) begin
            hw_count = {1'b0, wr_ptr} - {1'b0, rd_ptr};
        end else begin
            hw_count = {1'b0, wr_ptr} + (ADDR_W + 1)'(DEPTH) - {1'b0, rd_ptr};
        end
    end

    // a fetch owns the SRAM for its cycle
    assign write_hw = !buf_empty && !ring_full && !fetch;
    assign read_hw  = fetch && !ring_empty;

    // word leaves the buffer with its high half
    assign buf_pop = write_hw && wr_ptr[0];

    always_ff @(posedge BUS_CLK) begin
        if (clr) begin
            wr_ptr <= '0;
        end else if (write_hw) begin
            wr_ptr <= wr_ptr_next;
        end
    end

    always_ff @(posedge BUS_CLK) begin
        if (clr) begin
            rd_ptr <= '0;
        end else if (read_hw) begin
            rd_ptr <= rd_ptr_next;
        end
    end

    always_comb begin
        sram.addr  = fetch ? rd_ptr : wr_ptr;
        sram.wdata = wr_ptr[0] ? buf_word[31:16] : buf_word[15:0]; // low half first
        sram.we_b  = !write_hw;
        sram.oe_b  = !fetch;
    end

    always_comb begin
        fill.count = hw_count;
        fill.empty = ring_empty;
        fill.full  = ring_full;
    end

    // a write into a full ring would make it look empty
    a_no_write_full: assert property (@(posedge BUS_CLK) disable iff (clr)
        ring_full |=> !ring_empty)
        else $error("write pointer advanced into a full ring");

endmodule

`default_nettype wire

// ==== word_buffer.sv ====
// module word_buffer, a small circular buffer of 32-bit source words
`default_nettype none
`include "fifo_config.svh"

module word_buffer (
    input  wire         BUS_CLK,
    input  wire         clr,
    input  wire         fifo_empty_in,
    input  wire  [31:0] fifo_data,
    input  wire         buf_pop,
    output logic        read_next,
    output logic        buf_empty,
    output logic [31:0] buf_word
);

    localparam int unsigned DEPTH = `WORD_BUF_DEPTH;
    localparam int unsigned PTR_W = $clog2(DEPTH);
    localparam int unsigned CNT_W = $clog2(DEPTH + 1);

    logic [31:0]      mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             push;
    logic             pop;

    assign read_next = (count != CNT_W'(DEPTH)); // source may present its next word
    assign buf_empty = (count == '0);
    assign buf_word  = mem[rd_ptr];

    assign push = !fifo_empty_in && read_next;
    assign pop  = buf_pop && !buf_empty;

    always_ff @(posedge BUS_CLK) begin
        if (push) begin
            mem[wr_ptr] <= fifo_data;
        end
    end

    always_ff @(posedge BUS_CLK) begin
        if (clr) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count; // both or neither
            endcase
        end
    end

    // the ring controller only pops a word it has fully written
    a_no_pop_empty: assert property (@(posedge BUS_CLK) disable iff (clr)
        buf_pop |-> !buf_empty)
        else $error("word_buffer popped while empty");

    // pointers meet when full and a push past that would part them
    a_no_push_full: assert property (@(posedge BUS_CLK) disable iff (clr)
        (count == CNT_W'(DEPTH)) |-> (wr_ptr == rd_ptr))
        else $error("word_buffer pushed while full");

endmodule

`default_nettype wire

// ==== fifo_sram_pkg.sv ====
// package fifo_sram_pkg with the sram_cmd_t drive, fill_status_t and rd_state_e types
`default_nettype none
`include "fifo_config.svh"

package fifo_sram_pkg;

    // everything driven toward the SRAM in one cycle
    typedef struct packed {
        logic [`SRAM_ADDR_W-1:0] addr;
        logic [15:0]             wdata;
        logic                    we_b;  // plain write strobe, low for one cycle
        logic                    oe_b;  // low during a fetch
    } sram_cmd_t;

    // fill state of the ring, derived from the pointers
    typedef struct packed {
        logic [`SRAM_ADDR_W:0] count; // halfwords stored
        logic                  empty;
        logic                  full;
    } fill_status_t;

    // readout sequence
    typedef enum logic [1:0] {
        RD_WAIT  = 2'd0, // nothing held, ring empty
        RD_FETCH = 2'd1, // SRAM read cycle
        RD_HOLD  = 2'd2  // halfword held for the reader
    } rd_state_e;

endpackage

`default_nettype wire

// ==== fifo_bus_pkg.sv ====
// package fifo_bus_pkg with the bus_req_t transfer struct and the reg_addr_e register map
`default_nettype none

package fifo_bus_pkg;

    // one register bus transfer as seen on a clock edge
    typedef struct packed {
        logic [15:0] add;      // byte address
        logic [7:0]  data_in;  // write data
        logic        rd;
        logic        wr;
    } bus_req_t;

    // register map
    // addresses 1 and 2 also take the threshold writes
    typedef enum logic [15:0] {
        REG_CTRL  = 16'd0, // soft reset on write, version on read
        REG_SIZE0 = 16'd1, // byte count bits 7..0, almost-full on write
        REG_SIZE1 = 16'd2, // byte count bits 15..8, almost-empty on write
        REG_SIZE2 = 16'd3, // byte count bits 23..16
        REG_RDERR = 16'd4  // saturating read error count
    } reg_addr_e;

endpackage

`default_nettype wire

// ==== fifo_config.svh ====
// macros for SRAM ring depth, address width, word buffer depth, thresholds and version
`ifndef FIFO_CONFIG_SVH
`define FIFO_CONFIG_SVH

// ring size in 16-bit halfwords, kept even so a word never straddles the wrap
`define SRAM_DEPTH 512

// address lines on the external SRAM
`define SRAM_ADDR_W 20

// on-chip buffer ahead of the ring, in 32-bit words
`define WORD_BUF_DEPTH 16

// threshold reset values in percent of full scale
`define ALMOST_FULL_PCT 95
`define ALMOST_EMPTY_PCT 5

// readback value of the control register
`define FIFO_VERSION 1

`endif
